// File: Bender.yml
package:
  name: store_buffer

export_include_dirs:
  - .

sources:
  - sb_req_pkg.sv
  - sb_mem_pkg.sv
  - sb_alloc.sv
  - sb_entries.sv
  - sb_fwd.sv
  - store_buffer.sv
  - target: test
    files:
      - store_buffer_sva.sv
      - tb_store_buffer.sv

// File: sb_alloc.sv
`default_nettype none

`include "sb_cfg.svh"

module sb_alloc (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  sb_req_pkg::sb_store_req_t                 st_req,
   input  logic                                      commit,    // dc5 commit level
   output logic [`SB_DEPTH-1:0]                      wr_en,
   output sb_mem_pkg::sb_entry_t [`SB_DEPTH-1:0]     wr_entry,
   output logic [`SB_DEPTH-1:0]                      drain_en,
   output logic [`SB_DEPTH-1:0]                      flush_en,
   output logic [`SB_PTR_BITS-1:0]                   wr_ptr
);

   import sb_req_pkg::*;
   import sb_mem_pkg::*;

   // store in flight between dc3 and dc5
   typedef struct packed {
      logic                    vld;
      logic                    dual;
      logic [`SB_PTR_BITS-1:0] ptr;   // slot of the lo half
   } cmt_stage_t;

   logic [`SB_BYTES-1:0]     size_mask;
   logic [2*`SB_BYTES-1:0]   byteen_ext;
   logic                     st_dual;
   logic [`SB_PTR_BITS-1:0]  wr_ptr_p1;
   logic [`SB_PTR_BITS-1:0]  cmt_ptr_p1;
   sb_entry_t                lo_entry;
   sb_entry_t                hi_entry;
   cmt_stage_t               cmt_dc3;
   cmt_stage_t               cmt_dc4;
   cmt_stage_t               cmt_dc5;
   logic [`SB_DEPTH-1:0]     cmt_slot;

   // ------------------------------------------------------------
   // byte enables and the two halves
   // ------------------------------------------------------------
   always_comb begin
      case (st_req.size)
         SB_BYTE: size_mask = 8'h01;
         SB_HALF: size_mask = 8'h03;
         SB_WORD: size_mask = 8'h0f;
         default: size_mask = 8'hff;
      endcase
   end

   // lo bytes in [7:0], spill into the next doubleword in [15:8]
   assign byteen_ext = {{`SB_BYTES{1'b0}}, size_mask} << st_req.addr[`SB_OFS_BITS-1:0];

   assign st_dual = st_req.addr[`SB_OFS_BITS] != st_req.end_addr[`SB_OFS_BITS];

   assign lo_entry = '{addr:   st_req.addr,
                       byteen: byteen_ext[`SB_BYTES-1:0],
                       data:   st_req.data_lo};
   assign hi_entry = '{addr:   st_req.end_addr,
                       byteen: byteen_ext[2*`SB_BYTES-1:`SB_BYTES],
                       data:   st_req.data_hi};

   assign wr_ptr_p1 = wr_ptr + `SB_PTR_BITS'(1);

   // slot steering, lo goes to wr_ptr and hi to the slot after it
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         wr_en[i] = st_req.valid & ((wr_ptr == `SB_PTR_BITS'(i)) |
                                    (st_dual & (wr_ptr_p1 == `SB_PTR_BITS'(i))));
         wr_entry[i] = (wr_ptr == `SB_PTR_BITS'(i)) ? lo_entry : hi_entry;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (st_req.valid) begin
         wr_ptr <= wr_ptr + (st_dual ? `SB_PTR_BITS'(2) : `SB_PTR_BITS'(1));
      end
   end

   // ------------------------------------------------------------
   // commit pipe dc3 -> dc4 -> dc5
   // ------------------------------------------------------------
   assign cmt_dc3 = '{vld: st_req.valid, dual: st_dual, ptr: wr_ptr};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmt_dc4 <= '0;
         cmt_dc5 <= '0;
      end else begin
         cmt_dc4 <= cmt_dc3;
         cmt_dc5 <= cmt_dc4;
      end
   end

   assign cmt_ptr_p1 = cmt_dc5.ptr + `SB_PTR_BITS'(1);

   // one or two slots owned by the dc5 store
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         cmt_slot[i] = cmt_dc5.vld & ((cmt_dc5.ptr == `SB_PTR_BITS'(i)) |
                                      (cmt_dc5.dual & (cmt_ptr_p1 == `SB_PTR_BITS'(i))));
      end
   end

   assign drain_en = cmt_slot & {`SB_DEPTH{commit}};
   assign flush_en = cmt_slot & {`SB_DEPTH{~commit}};   // killed in dc5

endmodule

`default_nettype wire

// File: sb_cfg.svh
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// ------------------------------------------------------------
// store buffer sizing
// ------------------------------------------------------------

// entry count, power of two and at least 2
`define SB_DEPTH 4

// log2 of SB_DEPTH, keep in step with it
`define SB_PTR_BITS 2

// ------------------------------------------------------------
// address and data widths
// ------------------------------------------------------------

`define SB_ADDR_BITS 16   // byte address
`define SB_DATA_BITS 64   // one doubleword per entry
`define SB_BYTES 8        // byte lanes per entry
`define SB_OFS_BITS 3     // byte offset within a doubleword

`endif

// File: sb_entries.sv
`default_nettype none

`include "sb_cfg.svh"

module sb_entries (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [`SB_DEPTH-1:0]                  wr_en,
   input  sb_mem_pkg::sb_entry_t [`SB_DEPTH-1:0] wr_entry,
   input  logic [`SB_DEPTH-1:0]                  drain_en,
   input  logic [`SB_DEPTH-1:0]                  flush_en,
   input  logic                                  drain_ack,  // pop pulse from consumer
   output sb_mem_pkg::sb_drain_t                 drain,
   output sb_mem_pkg::sb_entry_t [`SB_DEPTH-1:0] ent,
   output logic [`SB_DEPTH-1:0]                  ent_vld,
   output logic [`SB_DEPTH-1:0]                  ent_flush,
   output logic                                  full,
   output logic                                  empty
);

   import sb_mem_pkg::*;

   localparam int CNT_W = `SB_PTR_BITS + 1;
   localparam logic [CNT_W-1:0] FULL_LVL = CNT_W'(`SB_DEPTH - 2);

   logic [`SB_DEPTH-1:0]    drain_vld;
   logic [`SB_PTR_BITS-1:0] rd_ptr;
   logic                    pop;
   logic [`SB_DEPTH-1:0]    clr;
   logic [CNT_W-1:0]        vld_cnt;
   sb_entry_t               head;

   // ------------------------------------------------------------
   // entry array
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         if (wr_en[i]) begin
            ent[i] <= wr_entry[i];
         end
      end
   end

   // flushed head leaves without an ack
   assign pop = (drain_ack & drain_vld[rd_ptr]) | ent_flush[rd_ptr];

   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         clr[i] = pop & (rd_ptr == `SB_PTR_BITS'(i));
      end
   end

   // per entry flags, clear has priority
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ent_vld   <= '0;
         drain_vld <= '0;
         ent_flush <= '0;
      end else begin
         for (int i = 0; i < `SB_DEPTH; i++) begin
            if (clr[i]) begin
               ent_vld[i]   <= 1'b0;
               drain_vld[i] <= 1'b0;
               ent_flush[i] <= 1'b0;
            end else begin
               if (wr_en[i]) begin
                  ent_vld[i] <= 1'b1;
               end
               if (drain_en[i]) begin
                  drain_vld[i] <= 1'b1;
               end
               if (flush_en[i]) begin
                  ent_flush[i] <= 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= rd_ptr + `SB_PTR_BITS'(1);
      end
   end

   // ------------------------------------------------------------
   // head and occupancy
   // ------------------------------------------------------------
   assign head  = ent[rd_ptr];
   assign drain = '{valid:   drain_vld[rd_ptr],
                    flushed: ent_flush[rd_ptr],
                    entry:   head};

   always_comb begin
      vld_cnt = '0;
      for (int i = 0; i < `SB_DEPTH; i++) begin
         vld_cnt = vld_cnt + CNT_W'(ent_vld[i]);
      end
   end

   assign full  = vld_cnt > FULL_LVL;   // room kept for a dual store
   assign empty = vld_cnt == '0;

endmodule

`default_nettype wire

// File: sb_fwd.sv
`default_nettype none

`include "sb_cfg.svh"

module sb_fwd (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  sb_req_pkg::sb_lookup_t                lookup,
   input  sb_mem_pkg::sb_entry_t [`SB_DEPTH-1:0] ent,
   input  logic [`SB_DEPTH-1:0]                  ent_vld,
   input  logic [`SB_DEPTH-1:0]                  ent_flush,
   input  logic [`SB_PTR_BITS-1:0]               wr_ptr,     // oldest slot when full
   output sb_mem_pkg::sb_fwd_t                   fwd
);

   import sb_mem_pkg::*;

   logic [`SB_DEPTH-1:0]                match;
   logic [`SB_DEPTH-1:0][`SB_BYTES-1:0] hit_byteen;
   sb_fwd_t                             fwd_d;

   // ------------------------------------------------------------
   // doubleword compare
   // ------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < `SB_DEPTH; i++) begin
         match[i] = lookup.en & ent_vld[i] & ~ent_flush[i] &
                    (ent[i].addr[`SB_ADDR_BITS-1:`SB_OFS_BITS] ==
                     lookup.addr[`SB_ADDR_BITS-1:`SB_OFS_BITS]);
         hit_byteen[i] = {`SB_BYTES{match[i]}} & ent[i].byteen;
      end
   end

   // ------------------------------------------------------------
   // byte merge
   // ------------------------------------------------------------
   // walk oldest to youngest so the younger store overwrites the byte
   always_comb begin
      logic [`SB_PTR_BITS-1:0] idx;
      fwd_d = '0;
      idx   = wr_ptr;
      for (int k = 0; k < `SB_DEPTH; k++) begin
         idx          = wr_ptr + `SB_PTR_BITS'(k);
         fwd_d.byteen = fwd_d.byteen | hit_byteen[idx];
         for (int b = 0; b < `SB_BYTES; b++) begin
            if (hit_byteen[idx][b]) begin
               fwd_d.data[8*b +: 8] = ent[idx].data[8*b +: 8];
            end
         end
      end
   end

   // result one cycle after the lookup
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fwd <= '0;
      end else begin
         fwd <= fwd_d;   // all zero without lookup.en
      end
   end

endmodule

`default_nettype wire

// File: sb_mem_pkg.sv
`default_nettype none

`include "sb_cfg.svh"

// what the buffer holds and what it hands out
package sb_mem_pkg;

   // one buffer entry
   typedef struct packed {
      logic [`SB_ADDR_BITS-1:0] addr;
      logic [`SB_BYTES-1:0]     byteen;
      logic [`SB_DATA_BITS-1:0] data;
   } sb_entry_t;

   // head entry offered to the consumer
   typedef struct packed {
      logic      valid;    // committed, wait for drain_ack
      logic      flushed;  // pops by itself
      sb_entry_t entry;
   } sb_drain_t;

   // merged load forward data
   typedef struct packed {
      logic [`SB_BYTES-1:0]     byteen;
      logic [`SB_DATA_BITS-1:0] data;
   } sb_fwd_t;

endpackage

`default_nettype wire

// File: sb_req_pkg.sv
`default_nettype none

`include "sb_cfg.svh"

// requests entering the store buffer from the lsu pipe
package sb_req_pkg;

   // access size, selects the low-bit byte mask
   typedef enum logic [1:0] {
      SB_BYTE  = 2'd0,
      SB_HALF  = 2'd1,
      SB_WORD  = 2'd2,
      SB_DWORD = 2'd3
   } sb_size_e;

   // store at the write stage (dc3)
   typedef struct packed {
      logic                     valid;
      logic [`SB_ADDR_BITS-1:0] addr;      // first byte
      logic [`SB_ADDR_BITS-1:0] end_addr;  // last byte
      sb_size_e                 size;
      logic [`SB_DATA_BITS-1:0] data_lo;   // aligned to addr's doubleword
      logic [`SB_DATA_BITS-1:0] data_hi;   // aligned to end_addr's doubleword
   } sb_store_req_t;

   // load lookup, one doubleword per request
   typedef struct packed {
      logic                     en;
      logic [`SB_ADDR_BITS-1:0] addr;
   } sb_lookup_t;

endpackage

`default_nettype wire

// File: store_buffer.f
+incdir+.
sb_req_pkg.sv
sb_mem_pkg.sv
sb_alloc.sv
sb_entries.sv
sb_fwd.sv
store_buffer.sv
store_buffer_sva.sv
tb_store_buffer.sv

// File: store_buffer.sv
`default_nettype none

`include "sb_cfg.svh"

module store_buffer (
   input  logic                      clk,
   input  logic                      rst_n,
   input  sb_req_pkg::sb_store_req_t st_req,
   input  logic                      commit,
   input  sb_req_pkg::sb_lookup_t    lookup,
   input  logic                      drain_ack,
   output sb_mem_pkg::sb_drain_t     drain,
   output sb_mem_pkg::sb_fwd_t       fwd,
   output logic                      full,
   output logic                      empty
);

   import sb_mem_pkg::*;

   logic [`SB_DEPTH-1:0]            wr_en;
   sb_entry_t [`SB_DEPTH-1:0]       wr_entry;
   logic [`SB_DEPTH-1:0]            drain_en;
   logic [`SB_DEPTH-1:0]            flush_en;
   logic [`SB_PTR_BITS-1:0]         wr_ptr;
   sb_entry_t [`SB_DEPTH-1:0]       ent;
   logic [`SB_DEPTH-1:0]            ent_vld;
   logic [`SB_DEPTH-1:0]            ent_flush;

   // write side and commit pipe
   sb_alloc u_alloc (
      .clk      (clk),
      .rst_n    (rst_n),
      .st_req   (st_req),
      .commit   (commit),
      .wr_en    (wr_en),
      .wr_entry (wr_entry),
      .drain_en (drain_en),
      .flush_en (flush_en),
      .wr_ptr   (wr_ptr)
   );

   sb_entries u_entries (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_en     (wr_en),
      .wr_entry  (wr_entry),
      .drain_en  (drain_en),
      .flush_en  (flush_en),
      .drain_ack (drain_ack),
      .drain     (drain),
      .ent       (ent),
      .ent_vld   (ent_vld),
      .ent_flush (ent_flush),
      .full      (full),
      .empty     (empty)
   );

   // load forwarding
   sb_fwd u_fwd (
      .clk       (clk),
      .rst_n     (rst_n),
      .lookup    (lookup),
      .ent       (ent),
      .ent_vld   (ent_vld),
      .ent_flush (ent_flush),
      .wr_ptr    (wr_ptr),
      .fwd       (fwd)
   );

endmodule

`default_nettype wire

// File: store_buffer_sva.sv
`default_nettype none

module store_buffer_sva (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  drain_ack,
   input sb_mem_pkg::sb_drain_t drain,
   input logic                  full,
   input logic                  empty
);

   logic err_seen = 1'b0;   // sticky, any assertion below failed

   // ------------------------------------------------------------
   // head flags
   // ------------------------------------------------------------
   a_head_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
         !(drain.valid && drain.flushed))
      else begin
         err_seen = 1'b1;
         $error("drain.valid and drain.flushed both high");
      end

   // nothing offered from an empty buffer
   a_empty_no_head: assert property (@(posedge clk) disable iff (!rst_n)
         empty |-> !drain.valid && !drain.flushed)
      else begin
         err_seen = 1'b1;
         $error("head offered while empty");
      end

   // ------------------------------------------------------------
   // occupancy and back-pressure
   // ------------------------------------------------------------
   a_empty_not_full: assert property (@(posedge clk) disable iff (!rst_n)
         empty |-> !full)
      else begin
         err_seen = 1'b1;
         $error("empty and full both high");
      end

   a_drain_hold: assert property (@(posedge clk) disable iff (!rst_n)
         drain.valid && !drain_ack |=> $stable(drain))
      else begin
         err_seen = 1'b1;
         $error("drain changed while waiting for drain_ack");
      end

endmodule

`default_nettype wire

// File: tb_store_buffer.sv
`default_nettype none

`include "sb_cfg.svh"

module tb_store_buffer;

   import sb_req_pkg::*;
   import sb_mem_pkg::*;

   localparam int          PERIOD   = 4;
   localparam int          N_STORES = 300;
   localparam logic [15:0] BASE     = 16'h4a40;  // small window, many dword hits
   localparam int          ST_PEND  = 0;
   localparam int          ST_CMT   = 1;
   localparam int          ST_FLUSH = 2;

   typedef struct {
      sb_entry_t e;
      int        sid;   // store number, shared by both halves of a dual
      int        st;
   } model_entry_t;

   logic          clk = 1'b0;
   logic          rst_n = 1'b0;
   sb_store_req_t st_req;
   logic          commit;
   sb_lookup_t    lookup;
   logic          drain_ack;
   sb_drain_t     drain;
   sb_fwd_t       fwd;
   logic          full;
   logic          empty;

   logic [15:0]   lfsr = 16'd55854;
   model_entry_t  mq[$];           // entries in buffer order, head first
   sb_fwd_t       exp_fwd = '0;
   int            issued = 0;
   int            s1_sid = -1;     // store driven one cycle ago
   int            s2_sid = -1;     // store now in dc5

   store_buffer DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .st_req    (st_req),
      .commit    (commit),
      .lookup    (lookup),
      .drain_ack (drain_ack),
      .drain     (drain),
      .fwd       (fwd),
      .full      (full),
      .empty     (empty)
   );

   bind store_buffer store_buffer_sva u_sva (
      .clk       (clk),
      .rst_n     (rst_n),
      .drain_ack (drain_ack),
      .drain     (drain),
      .full      (full),
      .empty     (empty)
   );

   always #(PERIOD/2) clk = ~clk;

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] exp,
                                  input logic [127:0] act);
      stop_run($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
   endtask

   // 16-bit fibonacci lfsr, taps 16 14 13 11
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[62:0], fb};
      end
      return r;
   endfunction

   // oldest to youngest, later writers overwrite the byte
   function automatic sb_fwd_t predict_fwd(input sb_lookup_t lk);
      sb_fwd_t r;
      r = '0;
      if (lk.en) begin
         foreach (mq[i]) begin
            if (mq[i].st != ST_FLUSH &&
                mq[i].e.addr[`SB_ADDR_BITS-1:`SB_OFS_BITS] ==
                lk.addr[`SB_ADDR_BITS-1:`SB_OFS_BITS]) begin
               r.byteen = r.byteen | mq[i].e.byteen;
               for (int b = 0; b < `SB_BYTES; b++) begin
                  if (mq[i].e.byteen[b]) begin
                     r.data[8*b +: 8] = mq[i].e.data[8*b +: 8];
                  end
               end
            end
         end
      end
      return r;
   endfunction

   function automatic logic [63:0] lane_mask(input logic [7:0] be);
      logic [63:0] m;
      for (int b = 0; b < 8; b++) begin
         m[8*b +: 8] = {8{be[b]}};
      end
      return m;
   endfunction

   // ------------------------------------------------------------
   // checks at the falling edge
   // ------------------------------------------------------------
   task automatic check_outputs();
      logic exp_vld;
      logic exp_fl;
      logic exp_full;
      logic exp_empty;
      int   cnt;
      cnt       = mq.size();
      exp_vld   = (cnt != 0) && (mq[0].st == ST_CMT);
      exp_fl    = (cnt != 0) && (mq[0].st == ST_FLUSH);
      exp_full  = cnt > `SB_DEPTH - 2;
      exp_empty = cnt == 0;
      assert (drain.valid === exp_vld)
         else report_mismatch("drain_valid", exp_vld, drain.valid);
      assert (drain.flushed === exp_fl)
         else report_mismatch("drain_flushed", exp_fl, drain.flushed);
      if (exp_vld || exp_fl) begin
         assert (drain.entry === mq[0].e)
            else report_mismatch("drain_entry", mq[0].e, drain.entry);
      end
      assert (full === exp_full) else report_mismatch("full", exp_full, full);
      assert (empty === exp_empty) else report_mismatch("empty", exp_empty, empty);
      assert (fwd.byteen === exp_fwd.byteen)
         else report_mismatch("fwd_byteen", exp_fwd.byteen, fwd.byteen);
      assert ((fwd.data & lane_mask(exp_fwd.byteen)) === exp_fwd.data)
         else report_mismatch("fwd_data", exp_fwd.data, fwd.data);
      assert (!DUT.u_sva.err_seen)
         else stop_run("a protocol assertion on the store buffer failed");
   endtask

   // ------------------------------------------------------------
   // drive one cycle and step the model to the next edge
   // ------------------------------------------------------------
   task automatic drive_cycle();
      model_entry_t m;
      logic [15:0]  be;
      logic         pop;
      int           tgt;
      tgt       = s2_sid;
      commit    = (rand_bits(3) != 0);   // mostly commit, some flushes
      drain_ack = (mq.size() != 0) && (mq[0].st == ST_CMT) && (rand_bits(1) != 0);
      lookup.en   = (rand_bits(2) != 0);
      lookup.addr = BASE | 16'(rand_bits(6));
      exp_fwd     = predict_fwd(lookup);
      st_req = '0;
      if (issued < N_STORES && !full && rand_bits(2) != 0) begin
         st_req.valid    = 1'b1;
         st_req.addr     = BASE | 16'(rand_bits(5));
         st_req.size     = sb_size_e'(2'(rand_bits(2)));
         st_req.end_addr = st_req.addr + ((16'd1 << st_req.size) - 16'd1);
         st_req.data_lo  = rand_bits(64);
         st_req.data_hi  = rand_bits(64);
      end
      // pop decided on the state before the edge
      pop = (mq.size() != 0) &&
            ((mq[0].st == ST_CMT && drain_ack) || mq[0].st == ST_FLUSH);
      if (pop) begin
         void'(mq.pop_front());
      end
      if (tgt >= 0) begin
         foreach (mq[i]) begin
            if (mq[i].sid == tgt) begin
               mq[i].st = commit ? ST_CMT : ST_FLUSH;
            end
         end
      end
      if (st_req.valid) begin
         be = 16'(1 << (1 << st_req.size)) - 16'd1;
         be = be << st_req.addr[2:0];
         m.sid      = issued;
         m.st       = ST_PEND;
         m.e.addr   = st_req.addr;
         m.e.byteen = be[7:0];
         m.e.data   = st_req.data_lo;
         mq.push_back(m);
         if (st_req.addr[3] != st_req.end_addr[3]) begin   // spills into next dword
            m.e.addr   = st_req.end_addr;
            m.e.byteen = be[15:8];
            m.e.data   = st_req.data_hi;
            mq.push_back(m);
         end
         issued++;
      end
      s2_sid = s1_sid;
      s1_sid = st_req.valid ? issued - 1 : -1;
   endtask

   // ------------------------------------------------------------
   // concurrent checks
   // ------------------------------------------------------------
   a_reset_state: assert property (@(posedge clk)
         $rose(rst_n) |-> empty && !full && !drain.valid && !drain.flushed &&
                          fwd.byteen == '0)
      else stop_run("outputs not at reset values after reset release");

   a_fwd_idle: assert property (@(posedge clk) disable iff (!rst_n)
         !lookup.en |=> fwd.byteen == '0)
      else stop_run("forward byte enables set without a lookup");

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      st_req    = '0;
      commit    = 1'b0;
      lookup    = '0;
      drain_ack = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (empty === 1'b1) else report_mismatch("reset_empty", 1, empty);
      assert (full === 1'b0) else report_mismatch("reset_full", 0, full);
      assert (drain.valid === 1'b0) else report_mismatch("reset_drain_valid", 0, drain.valid);
      assert (fwd.byteen === '0) else report_mismatch("reset_fwd_byteen", 0, fwd.byteen);
      while (issued < N_STORES || mq.size() != 0) begin
         check_outputs();
         drive_cycle();
         @(negedge clk);
      end
      check_outputs();
      if (DUT.u_sva.err_seen) begin
         stop_run("a protocol assertion on the store buffer failed");
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

   // watchdog
   initial begin
      #(N_STORES * 20 * PERIOD);
      stop_run("timeout, the store sequence did not finish");
   end

endmodule

`default_nettype wire
